//--- include/iq_macros.svh
// issue slice width macros
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// data and pc width fixed by the ISA
`define IQ_XLEN 32

// architectural integer registers
`define IQ_NREGS 32

// pc shown on a lane that carries nothing
`define IQ_PC_RESET 32'h1c00_0000

`endif

//--- src/iq_pkg.sv
// issue slice shared types
`default_nettype none

`include "iq_macros.svh"

package iq_pkg;

    typedef logic [`IQ_XLEN-1:0] word_t;
    typedef logic [$clog2(`IQ_NREGS)-1:0] reg_idx_t;

    // encodings are fixed so vector files can carry them as numbers
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } alu_op_e;

    // serial stands in for priv, syscall and break
    typedef enum logic {
        kind_alu    = 1'b0,
        kind_serial = 1'b1
    } uop_kind_e;

    typedef enum logic {
        st_pair   = 1'b0,
        st_second = 1'b1
    } split_state_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        uop_kind_e kind;
        alu_op_e   op;
        logic      use_imm;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        word_t     imm;
    } uop_t;

    typedef struct packed {
        uop_t slot0;
        uop_t slot1;
    } pair_t;

    typedef struct packed {
        uop_t lane0;
        uop_t lane1;
    } issue_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

endpackage

`default_nettype wire

//--- src/issue_split.sv
// dual issue splitter
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module issue_split (
    input  logic           clk,
    input  logic           rstn,
    input  iq_pkg::pair_t  in_pair,
    input  logic           in_valid,
    output logic           in_allowin,
    output iq_pkg::issue_t issue
);

    iq_pkg::split_state_e state_q;
    logic                 s0_rd_nz;
    logic                 raw_hazard;
    logic                 waw_hazard;
    logic                 dual_ok;
    logic                 need_split;

    // slot1 must not read or overwrite what slot0 produces
    assign s0_rd_nz   = in_pair.slot0.rd != '0;
    assign raw_hazard = s0_rd_nz && (in_pair.slot1.rj == in_pair.slot0.rd ||
                                     in_pair.slot1.rk == in_pair.slot0.rd);
    assign waw_hazard = s0_rd_nz && in_pair.slot1.rd != '0 &&
                        in_pair.slot1.rd == in_pair.slot0.rd;

    assign dual_ok = in_pair.slot0.valid && in_pair.slot1.valid &&
                     in_pair.slot0.kind == iq_pkg::kind_alu &&
                     in_pair.slot1.kind == iq_pkg::kind_alu &&
                     !raw_hazard && !waw_hazard;

    assign need_split = in_valid && in_pair.slot0.valid && in_pair.slot1.valid && !dual_ok;

    // hold upstream only during the first half of a split
    assign in_allowin = !(state_q == iq_pkg::st_pair && need_split);

    always_comb begin
        // empty lanes show the reset pc
        issue          = '0;
        issue.lane0.pc = `IQ_PC_RESET;
        issue.lane1.pc = `IQ_PC_RESET;
        if (in_valid) begin
            if (state_q == iq_pkg::st_second) begin
                issue.lane0 = in_pair.slot1;
            end else if (need_split || dual_ok) begin
                issue.lane0 = in_pair.slot0;
                if (dual_ok) begin
                    issue.lane1 = in_pair.slot1;
                end
            end else if (in_pair.slot0.valid) begin
                issue.lane0 = in_pair.slot0;
            end else if (in_pair.slot1.valid) begin
                // lone slot1 moves down to lane0
                issue.lane0 = in_pair.slot1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= iq_pkg::st_pair;
        end else if (state_q == iq_pkg::st_second) begin
            state_q <= iq_pkg::st_pair;
        end else if (need_split) begin
            state_q <= iq_pkg::st_second;
        end
    end

    // upstream keeps the pair presented until the second half goes
    a_second_holds_valid: assert property (
        @(posedge clk) disable iff (!rstn)
        state_q == iq_pkg::st_second |-> in_valid
    );

    a_lane1_needs_lane0: assert property (
        @(posedge clk) disable iff (!rstn)
        issue.lane1.valid |-> issue.lane0.valid
    );

endmodule

`default_nettype wire

//--- src/regfile.sv
// integer register file
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module regfile (
    input  logic             clk,
    input  logic             rstn,
    input  iq_pkg::reg_idx_t rd_idx0,
    input  iq_pkg::reg_idx_t rd_idx1,
    input  iq_pkg::reg_idx_t rd_idx2,
    input  iq_pkg::reg_idx_t rd_idx3,
    output iq_pkg::word_t    rd_data0,
    output iq_pkg::word_t    rd_data1,
    output iq_pkg::word_t    rd_data2,
    output iq_pkg::word_t    rd_data3,
    input  logic             wr_en0,
    input  logic             wr_en1,
    input  iq_pkg::reg_idx_t wr_idx0,
    input  iq_pkg::reg_idx_t wr_idx1,
    input  iq_pkg::word_t    wr_data0,
    input  iq_pkg::word_t    wr_data1
);

    iq_pkg::word_t regs [`IQ_NREGS];

    // r0 reads as zero
    assign rd_data0 = (rd_idx0 == '0) ? '0 : regs[rd_idx0];
    assign rd_data1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign rd_data2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];
    assign rd_data3 = (rd_idx3 == '0) ? '0 : regs[rd_idx3];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `IQ_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en0 && wr_idx0 != '0) begin
                regs[wr_idx0] <= wr_data0;
            end
            // port 1 is later in program order, so it wins
            if (wr_en1 && wr_idx1 != '0) begin
                regs[wr_idx1] <= wr_data1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/alu_pair.sv
// two lane alu with retire
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module alu_pair (
    input  logic             clk,
    input  logic             rstn,
    input  iq_pkg::issue_t   issue,
    output iq_pkg::reg_idx_t rd_idx0,
    output iq_pkg::reg_idx_t rd_idx1,
    output iq_pkg::reg_idx_t rd_idx2,
    output iq_pkg::reg_idx_t rd_idx3,
    input  iq_pkg::word_t    rd_data0,
    input  iq_pkg::word_t    rd_data1,
    input  iq_pkg::word_t    rd_data2,
    input  iq_pkg::word_t    rd_data3,
    output logic             wr_en0,
    output logic             wr_en1,
    output iq_pkg::reg_idx_t wr_idx0,
    output iq_pkg::reg_idx_t wr_idx1,
    output iq_pkg::word_t    wr_data0,
    output iq_pkg::word_t    wr_data1,
    output iq_pkg::retire_t  retire0,
    output iq_pkg::retire_t  retire1
);

    logic [1:0]       valid_q;
    iq_pkg::word_t    pc_q    [2];
    iq_pkg::reg_idx_t rd_q    [2];
    iq_pkg::word_t    value_q [2];
    iq_pkg::word_t    opb0;
    iq_pkg::word_t    opb1;
    iq_pkg::word_t    result0;
    iq_pkg::word_t    result1;

    function automatic iq_pkg::word_t alu_calc(input iq_pkg::alu_op_e op,
                                               input iq_pkg::word_t   a,
                                               input iq_pkg::word_t   b);
        logic lt;
        lt = $signed(a) < $signed(b);
        case (op)
            iq_pkg::op_add: return a + b;
            iq_pkg::op_sub: return a - b;
            iq_pkg::op_and: return a & b;
            iq_pkg::op_or:  return a | b;
            iq_pkg::op_xor: return a ^ b;
            // shift amount is the low five bits only
            iq_pkg::op_sll: return a << b[4:0];
            iq_pkg::op_srl: return a >> b[4:0];
            default:        return {{(`IQ_XLEN-1){1'b0}}, lt};
        endcase
    endfunction

    // ports 0/1 feed lane0, ports 2/3 feed lane1
    assign rd_idx0 = issue.lane0.rj;
    assign rd_idx1 = issue.lane0.rk;
    assign rd_idx2 = issue.lane1.rj;
    assign rd_idx3 = issue.lane1.rk;

    assign opb0    = issue.lane0.use_imm ? issue.lane0.imm : rd_data1;
    assign opb1    = issue.lane1.use_imm ? issue.lane1.imm : rd_data3;
    assign result0 = alu_calc(issue.lane0.op, rd_data0, opb0);
    assign result1 = alu_calc(issue.lane1.op, rd_data2, opb1);

    // writeback lands on the same edge as the retire record
    assign wr_en0   = issue.lane0.valid;
    assign wr_en1   = issue.lane1.valid;
    assign wr_idx0  = issue.lane0.rd;
    assign wr_idx1  = issue.lane1.rd;
    assign wr_data0 = result0;
    assign wr_data1 = result1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= {issue.lane1.valid, issue.lane0.valid};
        end
    end

    always_ff @(posedge clk) begin
        pc_q[0]    <= issue.lane0.pc;
        pc_q[1]    <= issue.lane1.pc;
        rd_q[0]    <= issue.lane0.rd;
        rd_q[1]    <= issue.lane1.rd;
        value_q[0] <= result0;
        value_q[1] <= result1;
    end

    assign retire0 = '{valid: valid_q[0], pc: pc_q[0], rd: rd_q[0], value: value_q[0]};
    assign retire1 = '{valid: valid_q[1], pc: pc_q[1], rd: rd_q[1], value: value_q[1]};

    // the splitter must never pair two writers of one register
    a_no_dual_waw: assert property (
        @(posedge clk) disable iff (!rstn)
        !(wr_en0 && wr_en1 && wr_idx0 == wr_idx1 && wr_idx0 != '0)
    );

endmodule

`default_nettype wire

//--- src/dual_issue_core.sv
// dual issue core top
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core (
    input  logic            clk,
    input  logic            rstn,
    input  iq_pkg::pair_t   in_pair,
    input  logic            in_valid,
    output logic            in_allowin,
    output iq_pkg::retire_t retire0,
    output iq_pkg::retire_t retire1
);

    iq_pkg::issue_t   issue;
    iq_pkg::reg_idx_t rd_idx0;
    iq_pkg::reg_idx_t rd_idx1;
    iq_pkg::reg_idx_t rd_idx2;
    iq_pkg::reg_idx_t rd_idx3;
    iq_pkg::word_t    rd_data0;
    iq_pkg::word_t    rd_data1;
    iq_pkg::word_t    rd_data2;
    iq_pkg::word_t    rd_data3;
    logic             wr_en0;
    logic             wr_en1;
    iq_pkg::reg_idx_t wr_idx0;
    iq_pkg::reg_idx_t wr_idx1;
    iq_pkg::word_t    wr_data0;
    iq_pkg::word_t    wr_data1;

    issue_split issue_split_i (
        .clk        (clk),
        .rstn       (rstn),
        .in_pair    (in_pair),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .issue      (issue)
    );

    regfile regfile_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_idx0  (rd_idx0),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_idx3  (rd_idx3),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .rd_data3 (rd_data3),
        .wr_en0   (wr_en0),
        .wr_en1   (wr_en1),
        .wr_idx0  (wr_idx0),
        .wr_idx1  (wr_idx1),
        .wr_data0 (wr_data0),
        .wr_data1 (wr_data1)
    );

    alu_pair alu_pair_i (
        .clk      (clk),
        .rstn     (rstn),
        .issue    (issue),
        .rd_idx0  (rd_idx0),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_idx3  (rd_idx3),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .rd_data3 (rd_data3),
        .wr_en0   (wr_en0),
        .wr_en1   (wr_en1),
        .wr_idx0  (wr_idx0),
        .wr_idx1  (wr_idx1),
        .wr_data0 (wr_data0),
        .wr_data1 (wr_data1),
        .retire0  (retire0),
        .retire1  (retire1)
    );

endmodule

`default_nettype wire

//--- tb/tb_dual_issue_core.sv
// dual issue core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;

    typedef struct packed {
        iq_pkg::word_t    pc;
        iq_pkg::reg_idx_t rd;
        iq_pkg::word_t    value;
    } expect_t;

    logic            clk;
    logic            rstn;
    iq_pkg::pair_t   in_pair;
    logic            in_valid;
    logic            in_allowin;
    iq_pkg::retire_t retire0;
    iq_pkg::retire_t retire1;

    iq_pkg::pair_t   pairs [$];
    iq_pkg::word_t   values0 [$];
    iq_pkg::word_t   values1 [$];
    expect_t         expect_q [$];
    logic [31:0]     fields [20];
    logic [31:0]     lcg_state;
    logic            loaded;

    dual_issue_core dual_issue_core_i (
        .clk        (clk),
        .rstn       (rstn),
        .in_pair    (in_pair),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .retire0    (retire0),
        .retire1    (retire1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    // dual rule worked out from the instruction pair alone
    function automatic logic pair_goes_dual(input iq_pkg::pair_t p);
        logic raw;
        logic waw;
        raw = p.slot0.rd != 5'd0 &&
              (p.slot1.rj == p.slot0.rd || p.slot1.rk == p.slot0.rd);
        waw = p.slot0.rd != 5'd0 && p.slot1.rd != 5'd0 && p.slot0.rd == p.slot1.rd;
        return p.slot0.valid && p.slot1.valid && p.slot0.kind == iq_pkg::kind_alu &&
               p.slot1.kind == iq_pkg::kind_alu && !raw && !waw;
    endfunction

    // nine fields per slot from index base
    function automatic iq_pkg::uop_t make_uop(input int base);
        iq_pkg::uop_t u;
        u.valid   = fields[base][0];
        u.pc      = fields[base+1];
        u.kind    = iq_pkg::uop_kind_e'(fields[base+2][0]);
        u.op      = iq_pkg::alu_op_e'(fields[base+3][2:0]);
        u.use_imm = fields[base+4][0];
        u.rd      = fields[base+5][4:0];
        u.rj      = fields[base+6][4:0];
        u.rk      = fields[base+7][4:0];
        u.imm     = fields[base+8];
        return u;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            stop_on_error($sformatf("error at %0t ns: %s is %h, expected %h",
                                    $time, name, got, want));
        end
    endtask

    task automatic load_vectors();
        int            fd;
        int            n;
        string         line;
        iq_pkg::pair_t p;
        fd = $fopen("tb/issue_vectors.txt", "r");
        assert (fd != 0) else stop_on_error("could not open tb/issue_vectors.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fields[0], fields[1], fields[2], fields[3], fields[4],
                            fields[5], fields[6], fields[7], fields[8], fields[9],
                            fields[10], fields[11], fields[12], fields[13], fields[14],
                            fields[15], fields[16], fields[17], fields[18], fields[19]);
                if (n == 20) begin
                    p.slot0 = make_uop(0);
                    p.slot1 = make_uop(9);
                    pairs.push_back(p);
                    values0.push_back(fields[18]);
                    values1.push_back(fields[19]);
                end else begin
                    assert (n <= 0) else stop_on_error("a vector line does not hold 20 fields");
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic push_expect(input iq_pkg::uop_t u, input iq_pkg::word_t value);
        expect_t e;
        e.pc    = u.pc;
        e.rd    = u.rd;
        e.value = value;
        expect_q.push_back(e);
    endtask

    task automatic check_retire(input string name, input iq_pkg::retire_t r);
        expect_t e;
        e = expect_q.pop_front();
        check_word({name, ".pc"}, r.pc, e.pc);
        check_word({name, ".rd"}, 32'(r.rd), 32'(e.rd));
        check_word({name, ".value"}, r.value, e.value);
    endtask

    // whatever issued last cycle retires now with the oldest on retire0
    always @(negedge clk) begin
        check_word("retire0.valid", 32'(retire0.valid), 32'(expect_q.size() > 0));
        if (retire0.valid) begin
            check_retire("retire0", retire0);
        end
        check_word("retire1.valid", 32'(retire1.valid), 32'(expect_q.size() > 0));
        if (retire1.valid) begin
            check_retire("retire1", retire1);
        end
    end

    initial begin
        wait (loaded);
        repeat ((pairs.size() + 5) * 20) @(posedge clk);
        $display("watchdog ran out after %0d vectors, the DUT looks hung", pairs.size());
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    end

    initial begin
        int            idle;
        int            hold;
        logic          dual;
        logic          split;
        logic          allow;
        iq_pkg::pair_t p;
        rstn      = 1'b0;
        in_valid  = 1'b0;
        in_pair   = '0;
        lcg_state = 32'd60977;
        loaded    = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < pairs.size(); i++) begin
            idle = int'(lcg_next() % 3);
            repeat (idle) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            p        = pairs[i];
            dual     = pair_goes_dual(p);
            split    = p.slot0.valid && p.slot1.valid && !dual;
            in_pair  = p;
            in_valid = 1'b1;
            hold     = 0;
            allow    = 1'b0;
            // hold the pair until the splitter takes it
            while (!allow) begin
                #1;
                allow = in_allowin;
                check_word("in_allowin", 32'(allow), 32'(!(split && hold == 0)));
                if (split) begin
                    if (hold == 0) begin
                        push_expect(p.slot0, values0[i]);
                    end else begin
                        push_expect(p.slot1, values1[i]);
                    end
                end else begin
                    if (p.slot0.valid) begin
                        push_expect(p.slot0, values0[i]);
                    end
                    if (p.slot1.valid) begin
                        push_expect(p.slot1, values1[i]);
                    end
                end
                @(negedge clk);
                hold++;
            end
        end
        in_valid = 1'b0;
        repeat (3) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/issue_vectors.txt
# per slot, hex: valid pc kind(0 alu 1 serial) op use_imm rd rj rk imm; slot0 then slot1
# last two columns: expected retire value of slot0 and of slot1
1 00001000 0 0 1 01 00 00 00000005  1 00001004 0 0 1 02 00 00 00000010  00000005 00000010
1 00001008 0 3 1 03 00 00 f0f0f0f0  1 0000100c 0 1 1 04 00 00 00000001  f0f0f0f0 ffffffff
1 00001010 0 0 0 05 01 02 00000000  1 00001014 0 0 1 06 05 00 00000100  00000015 00000115
1 00001018 1 4 0 07 03 04 00000000  1 0000101c 0 2 1 08 03 00 0000ff00  0f0f0f0f 0000f000
1 00001020 0 0 1 09 01 00 00000001  1 00001024 0 0 1 09 02 00 00000002  00000006 00000012
1 00001028 0 0 1 00 01 00 00000007  1 0000102c 0 0 1 0a 00 00 00000033  0000000c 00000033
1 00001030 0 3 0 00 03 00 00000000  1 00001034 0 4 1 00 04 00 00000000  f0f0f0f0 ffffffff
1 00001038 0 0 0 0b 00 00 00000000  1 0000103c 0 1 0 0c 00 01 00000000  00000000 fffffffb
1 00001040 0 0 0 0d 02 02 00000000  0 00001044 0 0 1 0d 0d 00 00000001  00000020 00000000
0 00001048 1 0 1 0e 00 00 00000005  1 0000104c 0 0 1 0e 0d 00 00000001  00000000 00000021
0 00001050 0 0 0 00 00 00 00000000  0 00001054 0 0 0 00 00 00 00000000  00000000 00000000
1 00001058 0 1 0 0f 06 05 00000000  1 0000105c 0 2 0 10 03 07 00000000  00000100 00000000
1 00001060 0 3 0 11 07 08 00000000  1 00001064 0 4 1 12 03 00 12345678  0f0fff0f e2c4a688
1 00001068 0 5 1 13 01 00 00000004  1 0000106c 0 6 1 14 04 00 0000001c  00000050 0000000f
1 00001070 0 5 0 15 01 0a 00000000  1 00001074 0 6 1 16 03 00 00000024  00280000 0f0f0f0f
1 00001078 0 7 0 17 0c 01 00000000  1 0000107c 0 7 1 18 01 00 ffffffff  00000001 00000000
1 00001080 0 7 0 19 01 04 00000000  1 00001084 0 7 1 1a 04 00 00000000  00000000 00000001
1 00001088 0 0 0 1b 04 01 00000000  1 0000108c 0 1 1 1c 02 00 00000020  00000004 fffffff0
1 00001090 0 2 1 1d 0c 00 000000ff  1 00001094 0 3 1 1e 00 00 80000000  000000fb 80000000
1 00001098 0 4 0 1f 1b 0f 00000000  1 0000109c 0 6 0 01 03 09 00000000  00000104 00003c3c
1 000010a0 0 5 0 02 01 01 00000000  1 000010a4 0 1 0 03 02 01 00000000  c0000000 bfffc3c4
1 000010a8 0 0 1 04 0d 00 7fffffff  1 000010ac 0 7 0 05 00 04 00000000  8000001f 00000000
1 000010b0 0 0 1 06 05 00 00000003  1 000010b4 1 3 1 07 00 00 00000abc  00000003 00000abc
1 000010b8 0 0 1 08 00 00 00000000  1 000010bc 0 3 0 09 00 00 00000000  00000000 00000000
1 000010c0 1 4 1 0a 0a 00 00000033  1 000010c4 1 1 0 0b 06 07 00000000  00000000 fffff547
1 000010c8 0 5 1 0c 06 00 0000003f  1 000010cc 0 6 1 0c 0c 00 0000001f  80000000 00000001
1 000010d0 0 0 0 0d 0c 0b 00000000  1 000010d4 0 0 0 0e 1f 01 00000000  fffff548 00003d40
0 000010d8 0 0 0 00 00 00 00000000  1 000010dc 1 0 1 0f 0e 00 00000000  00000000 00003d40
1 000010e0 0 1 0 10 0f 0e 00000000  1 000010e4 0 4 0 11 0d 0c 00000000  00000000 fffff549

//--- all.f
+incdir+include
src/iq_pkg.sv
src/issue_split.sv
src/regfile.sv
src/alu_pair.sv
src/dual_issue_core.sv
tb/tb_dual_issue_core.sv

//--- run.sh
#!/usr/bin/env bash
# build the dual issue testbench with Verilator, run it, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_dual_issue_core --Mdir "$OBJ" -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
